/* src/image_pkg.sv */
package image_pkg;

    localparam int IMG_WIDTH   = 320;
    localparam int KERNEL_SIZE = 11;
    localparam int HIST_ROWS   = KERNEL_SIZE - 1;
    localparam int COL_W       = 9;

    typedef logic [23:0] rgb_t;

    // Input beat, one pixel with its mask bit
    typedef struct packed {
        logic valid;
        logic sof;
        rgb_t rgb;
        logic mask;
    } pixel_in_t;

    // Column result handed from the row history stage to the window stage
    typedef struct packed {
        logic valid;
        logic first_col;
        logic col_hit;
        rgb_t rgb;
    } column_stage_t;

    typedef struct packed {
        logic valid;
        logic suppressed;
        rgb_t rgb;
    } pixel_out_t;

endpackage

/* src/wb_pkg.sv */
package wb_pkg;

    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 32;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] dat_r;
    } wb_rsp_t;

    typedef enum logic [WB_ADDR_W-1:0] {
        REG_CTRL  = 4'h0,
        REG_FILL  = 4'h4,
        REG_COUNT = 4'h8
    } reg_addr_e;

endpackage

/* src/suppress_regs.sv */
`timescale 1ns/1ps

module suppress_regs (
    input  logic             clk,
    input  logic             i_rst_n,
    input  wb_pkg::wb_req_t  i_wb,
    output wb_pkg::wb_rsp_t  o_wb,
    input  logic             i_suppressed,
    output logic             o_enable,
    output image_pkg::rgb_t  o_fill
);
    import wb_pkg::*;

    logic                 access;
    logic                 wr_en;
    reg_addr_e            addr;
    logic [WB_DATA_W-1:0] rd_data;
    logic [WB_DATA_W-1:0] count_q;

    // New request seen while no ack is pending
    assign access = i_wb.cyc & i_wb.stb & ~o_wb.ack;
    // Write lands on the acknowledged cycle
    assign wr_en  = o_wb.ack & i_wb.cyc & i_wb.stb & i_wb.we;
    assign addr   = reg_addr_e'(i_wb.adr);

    always_comb begin
        case (addr)
            REG_CTRL:  rd_data = {{(WB_DATA_W-1){1'b0}}, o_enable};
            REG_FILL:  rd_data = {{(WB_DATA_W-24){1'b0}}, o_fill};
            REG_COUNT: rd_data = count_q;
            default:   rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wb.ack <= 1'b0;
        end else begin
            o_wb.ack <= access;
        end
        if (access) begin
            o_wb.dat_r <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_enable <= 1'b0;
            o_fill   <= 24'hFFFFFF;
        end else if (wr_en) begin
            if (addr == REG_CTRL) begin
                o_enable <= i_wb.dat_w[0];
            end
            if (addr == REG_FILL) begin
                o_fill <= i_wb.dat_w[23:0];
            end
        end
    end

    // Any write to COUNT clears it, taking priority over a new hit
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            count_q <= '0;
        end else if (wr_en && addr == REG_COUNT) begin
            count_q <= '0;
        end else if (i_suppressed) begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

/* src/mask_column_history.sv */
`timescale 1ns/1ps

module mask_column_history (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  image_pkg::pixel_in_t     i_pix,
    output image_pkg::column_stage_t o_col
);
    import image_pkg::*;

    // One word per column, bit 0 is the most recent earlier row
    logic [HIST_ROWS-1:0] hist_mem [IMG_WIDTH];

    logic [COL_W-1:0]     col_cnt;
    logic                 first_row;
    logic [COL_W-1:0]     cur_col;
    logic                 cur_first_row;
    logic                 last_col;
    logic [HIST_ROWS-1:0] hist_word;

    // sof forces position back to the frame origin
    assign cur_col       = i_pix.sof ? '0 : col_cnt;
    assign cur_first_row = i_pix.sof ? 1'b1 : first_row;
    assign last_col      = (cur_col == COL_W'(IMG_WIDTH - 1));

    // Stale words from the previous frame are ignored on row 0
    assign hist_word = cur_first_row ? '0 : hist_mem[cur_col];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            col_cnt   <= '0;
            first_row <= 1'b1;
        end else if (i_pix.valid) begin
            if (last_col) begin
                col_cnt   <= '0;
                first_row <= 1'b0;
            end else begin
                col_cnt   <= cur_col + 1'b1;
                first_row <= cur_first_row;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_pix.valid) begin
            hist_mem[cur_col] <= {hist_word[HIST_ROWS-2:0], i_pix.mask};
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_col.valid <= 1'b0;
        end else begin
            o_col.valid <= i_pix.valid;
        end
        o_col.first_col <= (cur_col == '0);
        o_col.col_hit   <= i_pix.mask | (|hist_word);
        o_col.rgb       <= i_pix.rgb;
    end

endmodule

/* src/window_suppressor.sv */
`timescale 1ns/1ps

module window_suppressor (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  image_pkg::column_stage_t i_col,
    input  logic                     i_enable,
    input  image_pkg::rgb_t          i_fill,
    output image_pkg::pixel_out_t    o_pix
);
    import image_pkg::*;

    // Column hits of the previous columns in this row, bit 0 is the nearest
    logic [HIST_ROWS-1:0] hit_sr;
    logic [HIST_ROWS-1:0] hit_prev;
    logic                 suppress;

    // No history crosses a row boundary
    assign hit_prev = i_col.first_col ? '0 : hit_sr;
    assign suppress = i_enable & (i_col.col_hit | (|hit_prev));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            hit_sr <= '0;
        end else if (i_col.valid) begin
            hit_sr <= {hit_prev[HIST_ROWS-2:0], i_col.col_hit};
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_pix.valid      <= 1'b0;
            o_pix.suppressed <= 1'b0;
        end else begin
            o_pix.valid      <= i_col.valid;
            o_pix.suppressed <= i_col.valid & suppress;
        end
        o_pix.rgb <= suppress ? i_fill : i_col.rgb;
    end

endmodule

/* src/mask_suppress_top.sv */
`timescale 1ns/1ps

module mask_suppress_top (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  image_pkg::pixel_in_t  i_pix,
    output image_pkg::pixel_out_t o_pix,
    input  wb_pkg::wb_req_t       i_wb,
    output wb_pkg::wb_rsp_t       o_wb
);
    import image_pkg::*;

    column_stage_t col_stage;
    logic          enable;
    rgb_t          fill;

    // Stage one, vertical part of the window
    mask_column_history mask_column_history_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_pix   (i_pix),
        .o_col   (col_stage)
    );

    // Stage two, horizontal part and pixel replacement
    window_suppressor window_suppressor_inst (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_col    (col_stage),
        .i_enable (enable),
        .i_fill   (fill),
        .o_pix    (o_pix)
    );

    suppress_regs suppress_regs_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_wb         (i_wb),
        .o_wb         (o_wb),
        .i_suppressed (o_pix.suppressed),
        .o_enable     (enable),
        .o_fill       (fill)
    );

endmodule

/* tests/tb_mask_suppress.sv */
`timescale 1ns/1ps

module tb_mask_suppress;
    import image_pkg::*;
    import wb_pkg::*;

    localparam string CASE_FILE = "tests/suppress_cases.txt";

    logic       clk;
    logic       rst_n;
    pixel_in_t  pix_in;
    pixel_out_t pix_out;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;

    // Expected output beats delayed to line up with the two pipeline stages
    pixel_out_t exp_now;
    pixel_out_t exp_d1;
    pixel_out_t exp_d2;

    integer seed;
    longint watchdog_ns;
    int     q_enable[$];
    int     q_fill[$];
    int     q_rows[$];
    int     q_dot_row[$];
    int     q_dot_col[$];
    int     q_expect[$];

    mask_suppress_top mask_suppress_top_inst (
        .clk     (clk),
        .i_rst_n (rst_n),
        .i_pix   (pix_in),
        .o_pix   (pix_out),
        .i_wb    (wb_req),
        .o_wb    (wb_rsp)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Classic cycle that holds the request until the edge where ack is sampled
    task automatic bus_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] wdata,
                             output logic [WB_DATA_W-1:0] rdata);
        int waited;
        waited = 0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdata;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 16) begin
                $display("sim failed");
                $fatal(1, "the register block never acknowledged a bus request");
            end
        end while (!wb_rsp.ack);
        check_value("o_wb.ack latency", 32'(waited), 32'd1);
        rdata = wb_rsp.dat_r;
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic write_reg(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] data);
        logic [WB_DATA_W-1:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_expect(input string name, input logic [WB_ADDR_W-1:0] adr,
                               input logic [WB_DATA_W-1:0] expected);
        logic [WB_DATA_W-1:0] got;
        bus_cycle(1'b0, adr, '0, got);
        check_value(name, got, expected);
    endtask

    task automatic drive_beat(input logic valid, input logic sof, input rgb_t rgb,
                              input logic mask, input logic sup, input rgb_t out_rgb);
        pix_in.valid       = valid;
        pix_in.sof         = sof;
        pix_in.rgb         = rgb;
        pix_in.mask        = mask;
        exp_now.valid      = valid;
        exp_now.suppressed = sup;
        exp_now.rgb        = out_rgb;
        @(posedge clk);
        #1;
    endtask

    // Drives one frame with at most one mask dot and predicts it by the 11x11 window rule
    task automatic run_frame(input int enable, input rgb_t fill, input int rows,
                             input int dot_row, input int dot_col);
        logic [31:0] rnd;
        logic        mask;
        logic        hit;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < IMG_WIDTH; c++) begin
                rnd = $random(seed);
                if (rnd[2:0] == 3'd0) begin
                    drive_beat(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
                end
                rnd  = $random(seed);
                mask = (r == dot_row) && (c == dot_col);
                hit  = (enable != 0) && (dot_row >= 0)
                       && (r >= dot_row) && (r < dot_row + KERNEL_SIZE)
                       && (c >= dot_col) && (c < dot_col + KERNEL_SIZE);
                drive_beat(1'b1, (r == 0) && (c == 0), rnd[23:0], mask, hit,
                           hit ? fill : rnd[23:0]);
            end
        end
        // Two stages plus the counter update
        repeat (3) drive_beat(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic load_cases();
        int               fd;
        int               n;
        int               en;
        int               fill;
        int               rows;
        int               drow;
        int               dcol;
        int               expc;
        logic [8*128-1:0] line;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("sim failed");
            $fatal(1, "cannot open the case file %s", CASE_FILE);
        end
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                // Comment and blank lines do not match all six fields
                n = $sscanf(line, "%d %h %d %d %d %d", en, fill, rows, drow, dcol, expc);
                if (n == 6) begin
                    q_enable.push_back(en);
                    q_fill.push_back(fill);
                    q_rows.push_back(rows);
                    q_dot_row.push_back(drow);
                    q_dot_col.push_back(dcol);
                    q_expect.push_back(expc);
                end
            end
        end
        $fclose(fd);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_value("o_pix.valid", 32'(pix_out.valid), 32'(exp_d2.valid));
            if (exp_d2.valid) begin
                check_value("o_pix.suppressed", 32'(pix_out.suppressed),
                            32'(exp_d2.suppressed));
                check_value("o_pix.rgb", 32'(pix_out.rgb), 32'(exp_d2.rgb));
            end
        end
        exp_d2 = exp_d1;
        exp_d1 = exp_now;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("sim failed");
        $fatal(1, "the simulation timed out before all cases finished");
    end

    initial begin
        int   total_rows;
        rgb_t fill;
        seed        = 32'h7709;
        rst_n       = 1'b0;
        pix_in      = '0;
        wb_req      = '0;
        exp_now     = '0;
        exp_d1      = '0;
        exp_d2      = '0;
        watchdog_ns = 0;
        load_cases();
        if (q_rows.size() == 0) begin
            $display("sim failed");
            $fatal(1, "no test cases were found in %s", CASE_FILE);
        end
        total_rows = 0;
        foreach (q_rows[i]) begin
            total_rows += q_rows[i];
        end
        watchdog_ns = 2 * longint'(total_rows) * IMG_WIDTH * 4 + 2000;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // State straight out of reset
        read_expect("CTRL", REG_CTRL, 32'h0);
        read_expect("FILL", REG_FILL, 32'h00FFFFFF);
        read_expect("COUNT", REG_COUNT, 32'h0);
        read_expect("unmapped 0xC", 4'hC, 32'h0);

        foreach (q_rows[i]) begin
            fill = 24'(q_fill[i]);
            write_reg(REG_CTRL, (q_enable[i] != 0) ? 32'h1 : 32'h0);
            read_expect("CTRL", REG_CTRL, (q_enable[i] != 0) ? 32'h1 : 32'h0);
            write_reg(REG_FILL, {8'h00, fill});
            read_expect("FILL", REG_FILL, {8'h00, fill});
            write_reg(REG_COUNT, 32'h0);
            read_expect("COUNT", REG_COUNT, 32'h0);
            run_frame(q_enable[i], fill, q_rows[i], q_dot_row[i], q_dot_col[i]);
            read_expect("COUNT", REG_COUNT, 32'(q_expect[i]));
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* list.f */
src/image_pkg.sv
src/wb_pkg.sv
src/suppress_regs.sv
src/mask_column_history.sv
src/window_suppressor.sv
src/mask_suppress_top.sv
tests/tb_mask_suppress.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f list.f \
    --top-module tb_mask_suppress \
    -Mdir obj_dir \
    -o tb_mask_suppress

./obj_dir/tb_mask_suppress

/* tests/suppress_cases.txt */
# enable fill_hex rows dot_row dot_col expected_count
# dot_row -1 means the frame has no mask bit set
1 ffffff 20 3 5 121
1 00ff00 14 2 315 55
0 123456 12 1 1 0
1 a0b0c0 12 11 100 11
1 0000ff 12 -1 0 0
1 abcdef 16 0 0 121
